// File: csr_decode.sv
// write address decoder, one strobe per writable CSR
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
    input  logic               wr_en,
    input  csr_pkg::csr_addr_t wr_addr,
    input  csr_pkg::csr_data_t wr_data,
    csr_write_if.dec           wr
);

    assign wr.wdata = wr_data;

    always_comb begin
        wr.crmd_we   = 1'b0;
        wr.prmd_we   = 1'b0;
        wr.ecfg_we   = 1'b0;
        wr.estat_we  = 1'b0;
        wr.era_we    = 1'b0;
        wr.eentry_we = 1'b0;
        wr.save_we   = '0;
        wr.tid_we    = 1'b0;
        wr.tcfg_we   = 1'b0;
        wr.ticlr_we  = 1'b0;
        if (wr_en) begin
            case (wr_addr)
                csr_pkg::ADDR_CRMD:   wr.crmd_we    = 1'b1;
                csr_pkg::ADDR_PRMD:   wr.prmd_we    = 1'b1;
                csr_pkg::ADDR_ECFG:   wr.ecfg_we    = 1'b1;
                csr_pkg::ADDR_ESTAT:  wr.estat_we   = 1'b1;
                csr_pkg::ADDR_ERA:    wr.era_we     = 1'b1;
                csr_pkg::ADDR_EENTRY: wr.eentry_we  = 1'b1;
                csr_pkg::ADDR_SAVE0:  wr.save_we[0] = 1'b1;
                csr_pkg::ADDR_SAVE1:  wr.save_we[1] = 1'b1;
                csr_pkg::ADDR_SAVE2:  wr.save_we[2] = 1'b1;
                csr_pkg::ADDR_SAVE3:  wr.save_we[3] = 1'b1;
                csr_pkg::ADDR_TID:    wr.tid_we     = 1'b1;
                csr_pkg::ADDR_TCFG:   wr.tcfg_we    = 1'b1;
                csr_pkg::ADDR_TICLR:  wr.ticlr_we   = 1'b1;
                // unknown or read-only address, write dropped
                default: ;
            endcase
        end
    end

    // both register blocks rely on seeing at most one strobe
    always_comb begin
        assert ($onehot0({wr.crmd_we, wr.prmd_we, wr.ecfg_we, wr.estat_we, wr.era_we,
                          wr.eentry_we, wr.save_we, wr.tid_we, wr.tcfg_we, wr.ticlr_we}))
        else $error("csr write strobes not one-hot");
    end

endmodule

`default_nettype wire

// File: csr_pkg.sv
// shared types, CSR addresses, field positions and reset values
// for the exception and timer CSR block
`default_nettype none

package csr_pkg;

    // ========================================
    // types
    // ========================================
    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [7:0]  hw_int_t;
    typedef logic [12:0] int_vec_t;

    typedef enum logic {
        TIMER_IDLE  = 1'b0,
        TIMER_COUNT = 1'b1
    } timer_state_t;

    // ========================================
    // register addresses
    // ========================================
    localparam csr_addr_t ADDR_CRMD   = 14'h0;
    localparam csr_addr_t ADDR_PRMD   = 14'h1;
    localparam csr_addr_t ADDR_ECFG   = 14'h4;
    localparam csr_addr_t ADDR_ESTAT  = 14'h5;
    localparam csr_addr_t ADDR_ERA    = 14'h6;
    localparam csr_addr_t ADDR_EENTRY = 14'hc;
    localparam csr_addr_t ADDR_SAVE0  = 14'h30;
    localparam csr_addr_t ADDR_SAVE1  = 14'h31;
    localparam csr_addr_t ADDR_SAVE2  = 14'h32;
    localparam csr_addr_t ADDR_SAVE3  = 14'h33;
    localparam csr_addr_t ADDR_TID    = 14'h40;
    localparam csr_addr_t ADDR_TCFG   = 14'h41;
    localparam csr_addr_t ADDR_TVAL   = 14'h42;
    localparam csr_addr_t ADDR_TICLR  = 14'h44;

    // ========================================
    // field positions
    // ========================================
    localparam int CRMD_PLV_LSB     = 0;
    localparam int CRMD_IE          = 2;
    localparam int CRMD_DA          = 3;
    localparam int CRMD_PG          = 4;
    localparam int CRMD_DATF_LSB    = 5;
    localparam int CRMD_DATM_LSB    = 7;
    localparam int PRMD_PIE         = 2;
    localparam int ESTAT_TI         = 11;
    localparam int ESTAT_ECODE_LSB  = 16;
    localparam int ESTAT_ESUB_LSB   = 22;
    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INIT_LSB    = 2;
    localparam int TICLR_CLR        = 0;
    localparam int EENTRY_WRITE_LSB = 6;

    // reset values
    // direct address mode out of reset
    localparam csr_data_t CRMD_RESET = 32'h8;
    localparam int TVAL_SHIFT = 2;

endpackage

`default_nettype wire

// File: csr_read_mux.sv
// combinational CSR read select, unmapped addresses read zero
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
    input  csr_pkg::csr_addr_t rd_addr,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    input  csr_pkg::csr_data_t tid,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    output csr_pkg::csr_data_t rd_data
);

    always_comb begin
        case (rd_addr)
            csr_pkg::ADDR_CRMD:   rd_data = crmd;
            csr_pkg::ADDR_PRMD:   rd_data = prmd;
            csr_pkg::ADDR_ECFG:   rd_data = ecfg;
            csr_pkg::ADDR_ESTAT:  rd_data = estat;
            csr_pkg::ADDR_ERA:    rd_data = era;
            csr_pkg::ADDR_EENTRY: rd_data = eentry;
            csr_pkg::ADDR_SAVE0:  rd_data = save0;
            csr_pkg::ADDR_SAVE1:  rd_data = save1;
            csr_pkg::ADDR_SAVE2:  rd_data = save2;
            csr_pkg::ADDR_SAVE3:  rd_data = save3;
            csr_pkg::ADDR_TID:    rd_data = tid;
            csr_pkg::ADDR_TCFG:   rd_data = tcfg;
            csr_pkg::ADDR_TVAL:   rd_data = tval;
            // ticlr reads zero like any unmapped address
            default:              rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: csr_status_regs.sv
// trap state CSRs: CRMD, PRMD, ECFG, ESTAT, ERA, EENTRY and SAVE0-3
// handles exception entry and return, interrupt pending and early plv
`timescale 1ns/1ps
`default_nettype none

module csr_status_regs (
    input  logic                clk,
    input  logic                reset,
    csr_write_if.regs           wr,
    input  csr_pkg::hw_int_t    interrupt,
    input  logic                ti,
    input  logic                excp_flush,
    input  logic                ertn_flush,
    input  csr_pkg::csr_data_t  era_in,
    input  csr_pkg::ecode_t     ecode_in,
    input  csr_pkg::esubcode_t  esubcode_in,
    output csr_pkg::csr_data_t  crmd,
    output csr_pkg::csr_data_t  prmd,
    output csr_pkg::csr_data_t  ecfg,
    output csr_pkg::csr_data_t  estat,
    output csr_pkg::csr_data_t  era,
    output csr_pkg::csr_data_t  eentry,
    output csr_pkg::csr_data_t  save0,
    output csr_pkg::csr_data_t  save1,
    output csr_pkg::csr_data_t  save2,
    output csr_pkg::csr_data_t  save3,
    output logic                has_int,
    output csr_pkg::plv_t       plv
);

    csr_pkg::csr_data_t                  estat_q;
    logic [31:csr_pkg::EENTRY_WRITE_LSB] eentry_hi;
    csr_pkg::csr_data_t                  save_q [4];
    csr_pkg::int_vec_t                   pending;

    // ========================================
    // crmd / prmd
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= csr_pkg::CRMD_RESET;
        end else if (excp_flush) begin
            crmd[csr_pkg::CRMD_PLV_LSB +: 2] <= 2'b00;
            crmd[csr_pkg::CRMD_IE]           <= 1'b0;
        end else if (ertn_flush) begin
            crmd[csr_pkg::CRMD_PLV_LSB +: 2] <= prmd[1:0];
            crmd[csr_pkg::CRMD_IE]           <= prmd[csr_pkg::PRMD_PIE];
        end else if (wr.crmd_we) begin
            crmd[csr_pkg::CRMD_PLV_LSB +: 2]  <= wr.wdata[csr_pkg::CRMD_PLV_LSB +: 2];
            crmd[csr_pkg::CRMD_IE]            <= wr.wdata[csr_pkg::CRMD_IE];
            crmd[csr_pkg::CRMD_DA]            <= wr.wdata[csr_pkg::CRMD_DA];
            crmd[csr_pkg::CRMD_PG]            <= wr.wdata[csr_pkg::CRMD_PG];
            crmd[csr_pkg::CRMD_DATF_LSB +: 2] <= wr.wdata[csr_pkg::CRMD_DATF_LSB +: 2];
            crmd[csr_pkg::CRMD_DATM_LSB +: 2] <= wr.wdata[csr_pkg::CRMD_DATM_LSB +: 2];
        end
    end

    // ertn leaves prmd alone but still blocks a write
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd[1:0]               <= crmd[csr_pkg::CRMD_PLV_LSB +: 2];
            prmd[csr_pkg::PRMD_PIE] <= crmd[csr_pkg::CRMD_IE];
        end else if (wr.prmd_we && !ertn_flush) begin
            prmd[1:0]               <= wr.wdata[1:0];
            prmd[csr_pkg::PRMD_PIE] <= wr.wdata[csr_pkg::PRMD_PIE];
        end
    end

    // ========================================
    // ecfg / estat
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg <= '0;
        end else if (wr.ecfg_we) begin
            ecfg <= {19'b0, wr.wdata[12:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_q <= '0;
        end else begin
            // hw lines sampled every cycle
            estat_q[9:2] <= interrupt;
            if (wr.estat_we) begin
                estat_q[1:0] <= wr.wdata[1:0];
            end
            if (excp_flush) begin
                estat_q[csr_pkg::ESTAT_ECODE_LSB +: 6] <= ecode_in;
                estat_q[csr_pkg::ESTAT_ESUB_LSB +: 9]  <= esubcode_in;
            end
        end
    end

    // timer flag lives in csr_timer
    always_comb begin
        estat                    = estat_q;
        estat[csr_pkg::ESTAT_TI] = ti;
    end

    // ========================================
    // era / eentry / save
    // ========================================
    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era <= era_in;
        end else if (wr.era_we) begin
            era <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.eentry_we) begin
            eentry_hi <= wr.wdata[31:csr_pkg::EENTRY_WRITE_LSB];
        end
    end

    assign eentry = {eentry_hi, {csr_pkg::EENTRY_WRITE_LSB{1'b0}}};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr.save_we[i]) begin
                save_q[i] <= wr.wdata;
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

    // interrupt pending and forwarded plv
    assign pending = ecfg[12:0] & estat[12:0];
    assign has_int = crmd[csr_pkg::CRMD_IE] && (pending != '0);

    always_comb begin
        if (excp_flush) begin
            plv = 2'b00;
        end else if (ertn_flush) begin
            plv = prmd[1:0];
        end else begin
            plv = crmd[csr_pkg::CRMD_PLV_LSB +: 2];
        end
    end

    // pipeline never retires an exception and an ertn together
    flush_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(excp_flush && ertn_flush))
    else $error("excp_flush and ertn_flush high together");

endmodule

`default_nettype wire

// File: csr_stimulus.txt
# columns in hex: W addr data | R addr expected mask | E era ecode esubcode plv
# X plv | N cycles | I interrupt | H has_int | A era_out
R 0 00000008 ffffffff
H 0
R 5 00000000 ffffffff
R 4 00000000 ffffffff
W 30 11111111
R 30 11111111 ffffffff
W 31 22222222
R 31 22222222 ffffffff
W 32 33333333
R 32 33333333 ffffffff
W 33 44444444
R 33 44444444 ffffffff
W 40 0000abcd
R 40 0000abcd ffffffff
W 4 00000a5a
R 4 00000a5a ffffffff
W 6 1c000100
R 6 1c000100 ffffffff
W c 1c00803f
R c 1c008000 ffffffff
R 123 00000000 ffffffff
W 0 0000000f
R 0 0000000f ffffffff
E 1c000400 0b 1 0
R 1 00000007 ffffffff
R 0 00000008 ffffffff
R 6 1c000400 ffffffff
A 1c000400
R 5 004b0000 ffffffff
X 3
R 0 0000000f ffffffff
W 5 ffffffff
R 5 004b0003 ffffffff
W 5 00000000
W 4 00000000
W 41 00000009
N 8
R 5 00000000 00000800
R 5 00000800 00000800
R 42 ffffffff ffffffff
W 44 00000001
R 5 00000000 00000800
W 4 00000800
W 0 0000000c
W 41 00000007
N 4
R 5 00000000 00000800
R 5 00000800 00000800
H 1
W 44 00000001
H 0
R 5 00000000 00000800
R 5 00000800 00000800
W 0 00000008
H 0
W 41 00000000
W 44 00000001
W 4 00000004
W 0 0000000c
H 0
I 01
H 1
R 5 00000004 000003fc
I 00
H 0

// File: csr_timer.sv
// countdown timer CSRs TID, TCFG and TVAL with the timer interrupt flag
`timescale 1ns/1ps
`default_nettype none

module csr_timer (
    input  logic               clk,
    input  logic               reset,
    csr_write_if.regs          wr,
    output csr_pkg::csr_data_t tid,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               ti
);

    csr_pkg::timer_state_t state;
    csr_pkg::csr_data_t    load_val;
    csr_pkg::csr_data_t    reload_val;
    logic                  expire;
    logic                  clear;

    // initial value field scaled into tval units
    assign load_val   = (wr.wdata >> csr_pkg::TCFG_INIT_LSB) << csr_pkg::TVAL_SHIFT;
    assign reload_val = (tcfg >> csr_pkg::TCFG_INIT_LSB) << csr_pkg::TVAL_SHIFT;

    // a tcfg write in the same cycle restarts instead
    assign expire = (state == csr_pkg::TIMER_COUNT) && (tval == '0) && !wr.tcfg_we;
    assign clear  = wr.ticlr_we && wr.wdata[csr_pkg::TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (wr.tid_we) begin
            tid <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (wr.tcfg_we) begin
            tcfg <= wr.wdata;
        end
    end

    // ========================================
    // countdown FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= csr_pkg::TIMER_IDLE;
            tval  <= '1;
        end else if (wr.tcfg_we) begin
            tval  <= load_val;
            state <= wr.wdata[csr_pkg::TCFG_EN] ? csr_pkg::TIMER_COUNT : csr_pkg::TIMER_IDLE;
        end else if (expire) begin
            if (tcfg[csr_pkg::TCFG_PERIODIC]) begin
                tval <= reload_val;
            end else begin
                tval  <= '1;
                state <= csr_pkg::TIMER_IDLE;
            end
        end else if (state == csr_pkg::TIMER_COUNT) begin
            tval <= tval - 32'd1;
        end
    end

    // clear beats a new expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (clear) begin
            ti <= 1'b0;
        end else if (expire) begin
            ti <= 1'b1;
        end
    end

    ti_rise_on_expiry: assert property (@(posedge clk) disable iff (reset)
        $rose(ti) |-> $past((state == csr_pkg::TIMER_COUNT) && (tval == '0)))
    else $error("ti set without a counted-out timer");

endmodule

`default_nettype wire

// File: csr_top.sv
// exception and timer CSR file, top level
// write strobe, combinational read, flush pulses from the pipeline
`timescale 1ns/1ps
`default_nettype none

module csr_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  csr_pkg::csr_addr_t wr_addr,
    input  csr_pkg::csr_data_t wr_data,
    input  csr_pkg::csr_addr_t rd_addr,
    output csr_pkg::csr_data_t rd_data,
    input  csr_pkg::hw_int_t   interrupt,
    input  logic               excp_flush,
    input  logic               ertn_flush,
    input  csr_pkg::csr_data_t era_in,
    input  csr_pkg::ecode_t    ecode_in,
    input  csr_pkg::esubcode_t esubcode_in,
    output logic               has_int,
    output csr_pkg::plv_t      plv,
    output csr_pkg::csr_data_t era_out,
    output csr_pkg::csr_data_t eentry_out
);

    csr_write_if wr_bus ();

    csr_pkg::csr_data_t crmd;
    csr_pkg::csr_data_t prmd;
    csr_pkg::csr_data_t ecfg;
    csr_pkg::csr_data_t estat;
    csr_pkg::csr_data_t save0;
    csr_pkg::csr_data_t save1;
    csr_pkg::csr_data_t save2;
    csr_pkg::csr_data_t save3;
    csr_pkg::csr_data_t tid;
    csr_pkg::csr_data_t tcfg;
    csr_pkg::csr_data_t tval;
    logic               ti;

    csr_decode u_decode (
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr      (wr_bus.dec)
    );

    csr_status_regs u_status (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr_bus.regs),
        .interrupt   (interrupt),
        .ti          (ti),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .crmd        (crmd),
        .prmd        (prmd),
        .ecfg        (ecfg),
        .estat       (estat),
        .era         (era_out),
        .eentry      (eentry_out),
        .save0       (save0),
        .save1       (save1),
        .save2       (save2),
        .save3       (save3),
        .has_int     (has_int),
        .plv         (plv)
    );

    csr_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .wr    (wr_bus.regs),
        .tid   (tid),
        .tcfg  (tcfg),
        .tval  (tval),
        .ti    (ti)
    );

    csr_read_mux u_read_mux (
        .rd_addr (rd_addr),
        .crmd    (crmd),
        .prmd    (prmd),
        .ecfg    (ecfg),
        .estat   (estat),
        .era     (era_out),
        .eentry  (eentry_out),
        .save0   (save0),
        .save1   (save1),
        .save2   (save2),
        .save3   (save3),
        .tid     (tid),
        .tcfg    (tcfg),
        .tval    (tval),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: csr_write_if.sv
// decoded CSR write strobes and write data, from the decoder to the register blocks
`timescale 1ns/1ps
`default_nettype none

interface csr_write_if;

    logic               crmd_we;
    logic               prmd_we;
    logic               ecfg_we;
    logic               estat_we;
    logic               era_we;
    logic               eentry_we;
    logic [3:0]         save_we;
    logic               tid_we;
    logic               tcfg_we;
    logic               ticlr_we;
    csr_pkg::csr_data_t wdata;

    modport dec (
        output crmd_we, prmd_we, ecfg_we, estat_we, era_we, eentry_we,
        output save_we, tid_we, tcfg_we, ticlr_we, wdata
    );

    modport regs (
        input crmd_we, prmd_we, ecfg_we, estat_we, era_we, eentry_we,
        input save_we, tid_we, tcfg_we, ticlr_we, wdata
    );

endinterface

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_csr_top -Mdir obj_dir -f vlog.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_csr_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -Fqx ">>> PASS" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_csr_top.sv
// self-checking testbench for csr_top
// replays csr_stimulus.txt, one operation per line, one clock edge per operation
`timescale 1ns/1ps
`default_nettype none

module tb_csr_top;

    logic               clk = 1'b0;
    logic               reset;
    logic               wr_en;
    csr_pkg::csr_addr_t wr_addr;
    csr_pkg::csr_data_t wr_data;
    csr_pkg::csr_addr_t rd_addr;
    csr_pkg::csr_data_t rd_data;
    csr_pkg::hw_int_t   interrupt;
    logic               excp_flush;
    logic               ertn_flush;
    csr_pkg::csr_data_t era_in;
    csr_pkg::ecode_t    ecode_in;
    csr_pkg::esubcode_t esubcode_in;
    logic               has_int;
    csr_pkg::plv_t      plv;
    csr_pkg::csr_data_t era_out;
    csr_pkg::csr_data_t eentry_out;

    // one entry per stimulus line
    byte         op_code [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];
    logic [31:0] op_c [$];
    logic [31:0] op_d [$];

    int cycle_count = 0;
    int cycle_limit = 200;

    csr_top DUT (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .interrupt   (interrupt),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .era_in      (era_in),
        .ecode_in    (ecode_in),
        .esubcode_in (esubcode_in),
        .has_int     (has_int),
        .plv         (plv),
        .era_out     (era_out),
        .eentry_out  (eentry_out)
    );

    always #5 clk = ~clk;

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout, stimulus still running after %0d cycles", cycle_count);
            fail_run();
        end
    end

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    // ========================================
    // stimulus file
    // ========================================
    task automatic load_stimulus(output int wait_sum);
        int          fd;
        int          fields;
        string       line;
        byte         code;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        wait_sum = 0;
        fd = $fopen("csr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open csr_stimulus.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            fields = $sscanf(line, "%c %h %h %h %h", code, a, b, c, d);
            op_code.push_back(code);
            op_a.push_back(a);
            op_b.push_back(b);
            op_c.push_back(c);
            op_d.push_back(d);
            if (code == "N") begin
                wait_sum += int'(a);
            end
        end
        $fclose(fd);
    endtask

    // checks land on the falling edge, mid cycle
    task automatic run_op(byte code, logic [31:0] a, logic [31:0] b,
                          logic [31:0] c, logic [31:0] d);
        case (code)
            "W": begin
                wr_en   = 1'b1;
                wr_addr = a[13:0];
                wr_data = b;
                step_clock();
                wr_en   = 1'b0;
            end
            "R": begin
                rd_addr = a[13:0];
                @(negedge clk);
                check_value($sformatf("rd_data@0x%h", a[13:0]), b, rd_data & c);
                // eentry also leaves the top level on its own port
                if (a[13:0] == csr_pkg::ADDR_EENTRY) begin
                    check_value("eentry_out", b, eentry_out & c);
                end
                step_clock();
            end
            "E": begin
                era_in      = a;
                ecode_in    = b[5:0];
                esubcode_in = c[8:0];
                excp_flush  = 1'b1;
                @(negedge clk);
                check_value("plv", {30'b0, d[1:0]}, {30'b0, plv});
                step_clock();
                excp_flush  = 1'b0;
            end
            "X": begin
                ertn_flush = 1'b1;
                @(negedge clk);
                check_value("plv", {30'b0, a[1:0]}, {30'b0, plv});
                step_clock();
                ertn_flush = 1'b0;
            end
            "N": repeat (a) step_clock();
            "I": begin
                interrupt = a[7:0];
                step_clock();
            end
            "H": begin
                @(negedge clk);
                check_value("has_int", a & 32'h1, {31'b0, has_int});
                step_clock();
            end
            "A": begin
                @(negedge clk);
                check_value("era_out", a, era_out);
                step_clock();
            end
            default: begin
                $display("unknown stimulus operation '%c'", code);
                fail_run();
            end
        endcase
    endtask

    initial begin
        int wait_sum;
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_addr     = '0;
        interrupt   = '0;
        excp_flush  = 1'b0;
        ertn_flush  = 1'b0;
        era_in      = '0;
        ecode_in    = '0;
        esubcode_in = '0;
        load_stimulus(wait_sum);
        cycle_limit = wait_sum + 200;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < op_code.size(); i++) begin
            run_op(op_code[i], op_a[i], op_b[i], op_c[i], op_d[i]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
csr_pkg.sv
csr_write_if.sv
csr_decode.sv
csr_status_regs.sv
csr_timer.sv
csr_read_mux.sv
csr_top.sv
tb_csr_top.sv
